// ==== hist_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

module hist_ctrl
  import texture_hist_pkg::*;
(
  input  logic   clk,
  input  logic   rst_n,
  input  logic   start_i,
  input  logic   read_en_i,
  input  logic   code_last_i,
  input  count_t rd_count_i,
  output logic   accum_en_o,
  output logic   clear_o,
  output bin_t   rd_bin_o,
  output bin_t   hist_bin_o,
  output count_t hist_o,
  output logic   hist_valid_o,
  output logic   read_finish_o,
  output logic   busy_o
);

  ctrl_state_e state_q;
  bin_t        rd_idx_q;
  logic        rd_done;
  logic        rd_fire;

  assign rd_done = hist_valid_o && (hist_bin_o == BIN_W'(NUM_BINS - 1)); // Last bin shown.
  assign rd_fire = (state_q == ST_READ) && read_en_i && !rd_done;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q      <= ST_IDLE;
      rd_idx_q     <= '0;
      hist_valid_o <= 1'b0;
    end else begin
      hist_valid_o <= rd_fire;
      case (state_q)
        ST_IDLE: begin
          if (start_i) begin
            state_q <= ST_ACCUM;
          end
        end
        ST_ACCUM: begin
          if (code_last_i) begin
            state_q  <= ST_READ; // Lands with the final increment.
            rd_idx_q <= '0;
          end
        end
        ST_READ: begin
          if (rd_done) begin
            state_q <= ST_FINISH;
          end else if (read_en_i) begin
            rd_idx_q <= rd_idx_q + 1'b1;
          end
        end
        default: begin
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rd_fire) begin
      hist_o     <= rd_count_i;
      hist_bin_o <= rd_idx_q;
    end
  end

  assign accum_en_o    = (state_q == ST_ACCUM);
  assign clear_o       = (state_q == ST_IDLE) && start_i;
  assign rd_bin_o      = rd_idx_q;
  assign read_finish_o = (state_q == ST_FINISH);
  assign busy_o        = (state_q != ST_IDLE);

endmodule

`default_nettype wire

// ==== joint_hist.sv ====
`timescale 1ns/1ns
`default_nettype none

module joint_hist
  import texture_hist_pkg::*;
(
  input  logic   clk,
  input  logic   rst_n,
  input  logic   clear_i,
  input  logic   inc_i,
  input  bin_t   inc_bin_i,
  input  bin_t   rd_bin_i,
  output count_t rd_count_o
);

  count_t cnt_q [NUM_BINS];

  // One increment per cycle, so a repeated bin just counts again.
  always_ff @(posedge clk) begin
    if (!rst_n || clear_i) begin
      for (int b = 0; b < NUM_BINS; b++) begin
        cnt_q[b] <= '0;
      end
    end else if (inc_i) begin
      cnt_q[inc_bin_i] <= cnt_q[inc_bin_i] + 1'b1;
    end
  end

  assign rd_count_o = cnt_q[rd_bin_i];

endmodule

`default_nettype wire

// ==== line_window.sv ====
`timescale 1ns/1ns
`default_nettype none

module line_window
  import texture_hist_pkg::*;
(
  input  logic clk,
  input  logic rst_n,
  input  pix_t pix_i,
  input  logic step_i,
  input  logic center_ok_i,
  input  logic last_i,
  output pix_t win_o [9],
  output logic win_valid_o,
  output logic win_last_o
);

  // Line 0 holds the previous row, line 1 the row before it.
  pix_t line_q [2][IMG_COLS];
  pix_t win_q [9];

  always_ff @(posedge clk) begin
    if (step_i) begin
      for (int i = IMG_COLS - 1; i > 0; i--) begin
        line_q[0][i] <= line_q[0][i-1];
        line_q[1][i] <= line_q[1][i-1];
      end
      line_q[0][0] <= pix_i;
      line_q[1][0] <= line_q[0][IMG_COLS-1];
    end
  end

  always_ff @(posedge clk) begin
    if (step_i) begin
      for (int r = 0; r < 3; r++) begin
        win_q[3*r]   <= win_q[3*r+1];
        win_q[3*r+1] <= win_q[3*r+2];
      end
      win_q[2] <= line_q[1][IMG_COLS-1]; // Two rows up.
      win_q[5] <= line_q[0][IMG_COLS-1]; // One row up.
      win_q[8] <= pix_i;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      win_valid_o <= 1'b0;
      win_last_o  <= 1'b0;
    end else begin
      win_valid_o <= step_i && center_ok_i;
      win_last_o  <= step_i && last_i;
    end
  end

  assign win_o = win_q;

endmodule

`default_nettype wire

// ==== median_code.sv ====
`timescale 1ns/1ns
`default_nettype none

module median_code
  import texture_hist_pkg::*;
(
  input  logic clk,
  input  logic rst_n,
  input  pix_t win_i [9],
  input  logic win_valid_i,
  input  logic win_last_i,
  output bin_t code_bin_o,
  output logic code_valid_o,
  output logic code_last_o
);

  pix_t       median;
  logic       ci;
  logic [3:0] ni;

  always_comb begin
    pix_t srt [9];
    pix_t lo_v;
    pix_t hi_v;
    srt = win_i;
    for (int k = 0; k < MED_CAS_N; k++) begin
      lo_v = srt[MED_CAS_LO[k]];
      hi_v = srt[MED_CAS_HI[k]];
      if (lo_v > hi_v) begin
        srt[MED_CAS_LO[k]] = hi_v;
        srt[MED_CAS_HI[k]] = lo_v;
      end
    end
    median = srt[4];
  end

  assign ci = (win_i[4] >= median);
  assign ni = {win_i[1] >= median,  // North.
               win_i[5] >= median,  // East.
               win_i[7] >= median,  // South.
               win_i[3] >= median}; // West.

  always_ff @(posedge clk) begin
    code_bin_o <= {ci, ni};
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      code_valid_o <= 1'b0;
      code_last_o  <= 1'b0;
    end else begin
      code_valid_o <= win_valid_i;
      code_last_o  <= win_last_i;
    end
  end

endmodule

`default_nettype wire

// ==== raster_counter.sv ====
`timescale 1ns/1ns
`default_nettype none

module raster_counter
  import texture_hist_pkg::*;
(
  input  logic clk,
  input  logic rst_n,
  input  logic clear_i,
  input  logic step_i,
  output logic center_ok_o,
  output logic frame_last_o
);

  logic [COL_W-1:0] col_q;
  logic [ROW_W-1:0] row_q;
  logic             col_end;
  logic             row_end;

  assign col_end = (col_q == COL_W'(IMG_COLS - 1));
  assign row_end = (row_q == ROW_W'(IMG_ROWS - 1));

  always_ff @(posedge clk) begin
    if (!rst_n || clear_i) begin
      col_q <= '0;
      row_q <= '0;
    end else if (step_i) begin
      if (col_end) begin
        col_q <= '0;
        row_q <= row_end ? '0 : row_q + 1'b1; // Wrap at end of frame.
      end else begin
        col_q <= col_q + 1'b1;
      end
    end
  end

  // Window centered one row and one column back is fully inside.
  assign center_ok_o  = (row_q >= ROW_W'(2)) && (col_q >= COL_W'(2));
  assign frame_last_o = row_end && col_end;

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ns \
  --top-module texture_hist_tb -f texture_hist_top.f -o texture_hist_sim &&
  ./obj_dir/texture_hist_sim | tee /dev/stderr | grep -qx "all tests passed" &&
  echo "Simulation passed." ||
  { echo "Simulation failed."; exit 1; }

// ==== texture_hist_chk.sv ====
`timescale 1ns/1ns
`default_nettype none

module texture_hist_chk
  import texture_hist_pkg::*;
(
  input logic clk,
  input logic rst_n,
  input logic hist_valid_i,
  input logic read_finish_i,
  input logic busy_i,
  input bin_t hist_bin_i
);

  bin_t last_bin_q;
  logic have_prev_q;

  always_ff @(posedge clk) begin
    if (!rst_n || read_finish_i) begin
      have_prev_q <= 1'b0; // Next read-out starts over at bin 0.
    end else if (hist_valid_i) begin
      have_prev_q <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (hist_valid_i) begin
      last_bin_q <= hist_bin_i;
    end
  end

  valid_in_read_a: assert property (@(posedge clk) disable iff (!rst_n)
    hist_valid_i |-> busy_i && !read_finish_i)
    else $error("hist_valid_o seen outside read-out");

  finish_pulse_a: assert property (@(posedge clk) disable iff (!rst_n)
    read_finish_i |=> !read_finish_i)
    else $error("read_finish_o held longer than one cycle");

  first_bin_a: assert property (@(posedge clk) disable iff (!rst_n)
    (hist_valid_i && !have_prev_q) |-> hist_bin_i == bin_t'(0))
    else $error("read-out did not begin at bin 0");

  bin_step_a: assert property (@(posedge clk) disable iff (!rst_n)
    (hist_valid_i && have_prev_q) |-> hist_bin_i == bin_t'(last_bin_q + 1'b1))
    else $error("hist_bin_o skipped or repeated a bin");

endmodule

bind texture_hist_top texture_hist_chk texture_hist_chk_i (
  .clk           (clk),
  .rst_n         (rst_n),
  .hist_valid_i  (hist_valid_o),
  .read_finish_i (read_finish_o),
  .busy_i        (busy_o),
  .hist_bin_i    (hist_bin_o)
);

`default_nettype wire

// ==== texture_hist_pkg.sv ====
`default_nettype none

package texture_hist_pkg;

  localparam int IMG_COLS = 8;
  localparam int IMG_ROWS = 8;
  localparam int PIX_W    = 8;
  localparam int NUM_BINS = 32;
  localparam int BIN_W    = 5;
  localparam int CNT_W    = 16;
  localparam int COL_W    = 3;
  localparam int ROW_W    = 3;

  // Median-of-nine network of 19 compare-exchange steps.
  // Each step leaves the smaller value at LO and the larger at HI.
  localparam int MED_CAS_N = 19;
  localparam int MED_CAS_LO [MED_CAS_N] = '{1, 4, 7, 0, 3, 6, 1, 4, 7, 0,
                                            5, 4, 3, 1, 2, 4, 4, 6, 4};
  localparam int MED_CAS_HI [MED_CAS_N] = '{2, 5, 8, 1, 4, 7, 2, 5, 8, 3,
                                            8, 7, 6, 4, 5, 7, 2, 4, 2};

  typedef logic [PIX_W-1:0] pix_t;
  typedef logic [BIN_W-1:0] bin_t;
  typedef logic [CNT_W-1:0] count_t;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ACCUM,
    ST_READ,
    ST_FINISH
  } ctrl_state_e;

endpackage

`default_nettype wire

// ==== texture_hist_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module texture_hist_tb
  import texture_hist_pkg::*;
();

  localparam int NPIX       = IMG_ROWS * IMG_COLS;
  localparam int NWIN       = (IMG_ROWS - 2) * (IMG_COLS - 2);
  localparam int WAIT_LIMIT = 400;

  logic   clk = 1'b0;
  logic   rst_n;
  logic   start;
  logic   pix_valid;
  logic   read_en;
  pix_t   pix;
  count_t hist;
  bin_t   hist_bin;
  logic   hist_valid;
  logic   read_finish;
  logic   busy;

  logic [31:0] rng_state = 32'h2662_f686;
  pix_t        frame [NPIX];
  int          exp_cnt [NUM_BINS];
  int          err_cnt = 0;
  int          test_cnt = 0;
  int          bad_test_cnt = 0;
  int          test_err_base = 0;

  texture_hist_top texture_hist_top_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .start_i       (start),
    .pix_valid_i   (pix_valid),
    .read_en_i     (read_en),
    .pix_i         (pix),
    .hist_o        (hist),
    .hist_bin_o    (hist_bin),
    .hist_valid_o  (hist_valid),
    .read_finish_o (read_finish),
    .busy_o        (busy)
  );

  always #20 clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  task automatic check_count(input count_t got, input count_t exp, input string what);
    if (got !== exp) begin
      err_cnt++;
      $display("** Error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_bin(input bin_t got, input bin_t exp, input string what);
    if (got !== exp) begin
      err_cnt++;
      $display("** Error at %0t ns: %s gave bin %0d, expected bin %0d", $time, what, got, exp);
    end
  endtask

  task automatic abort_run(input string what);
    $display("Timeout while waiting for %s.", what);
    $display("tests failed");
    $finish;
  endtask

  task automatic wait_busy(input logic level, input string what);
    int n;
    n = 0;
    while (busy !== level) begin
      @(negedge clk);
      n++;
      if (n > WAIT_LIMIT) begin
        abort_run(what);
      end
    end
  endtask

  task automatic apply_reset();
    rst_n = 1'b0;
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
  endtask

  // Expected counts from the median and code rules on interior windows.
  task automatic build_expected();
    pix_t srt [9];
    pix_t tmp;
    pix_t med;
    int   j;
    int   bin;
    for (int b = 0; b < NUM_BINS; b++) begin
      exp_cnt[b] = 0;
    end
    for (int r = 1; r < IMG_ROWS - 1; r++) begin
      for (int c = 1; c < IMG_COLS - 1; c++) begin
        for (int k = 0; k < 9; k++) begin
          srt[k] = frame[(r - 1 + k / 3) * IMG_COLS + c - 1 + k % 3];
        end
        for (int k = 1; k < 9; k++) begin // Insertion sort.
          tmp = srt[k];
          j = k - 1;
          while (j >= 0 && srt[j] > tmp) begin
            srt[j + 1] = srt[j];
            j--;
          end
          srt[j + 1] = tmp;
        end
        med = srt[4];
        bin = 0;
        if (frame[r * IMG_COLS + c] >= med) bin += 16;
        if (frame[(r - 1) * IMG_COLS + c] >= med) bin += 8; // North.
        if (frame[r * IMG_COLS + c + 1] >= med) bin += 4;   // East.
        if (frame[(r + 1) * IMG_COLS + c] >= med) bin += 2; // South.
        if (frame[r * IMG_COLS + c - 1] >= med) bin += 1;   // West.
        exp_cnt[bin]++;
      end
    end
  endtask

  task automatic fill_random(input bit coarse);
    logic [31:0] r;
    for (int i = 0; i < NPIX; i++) begin
      r = next_rand();
      frame[i] = coarse ? {r[12:10], 5'b0} : r[7:0]; // Coarse levels force ties.
    end
  endtask

  task automatic start_frame();
    wait_busy(1'b0, "idle before start");
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
    wait_busy(1'b1, "busy after start");
  endtask

  task automatic send_frame(input bit stalls);
    logic [31:0] r;
    for (int i = 0; i < NPIX; i++) begin
      r = next_rand();
      if (stalls && r[1:0] == 2'b00) begin
        pix_valid = 1'b0;
        pix = r[15:8]; // Junk on a stall cycle.
        @(negedge clk);
      end
      pix_valid = 1'b1;
      pix = frame[i];
      @(negedge clk);
    end
    pix_valid = 1'b0;
  endtask

  task automatic read_hist(input bit toggle, output int total);
    logic [31:0] r;
    int next_bin;
    int finishes;
    int n;
    next_bin = 0;
    finishes = 0;
    n = 0;
    total = 0;
    read_en = 1'b1;
    while (finishes == 0) begin
      @(negedge clk);
      n++;
      if (n > WAIT_LIMIT) begin
        abort_run("the end of read-out");
      end
      if (hist_valid) begin
        if (next_bin < NUM_BINS) begin
          check_bin(hist_bin, bin_t'(next_bin), "Read-out order");
          check_count(hist, count_t'(exp_cnt[next_bin]), $sformatf("Bin %0d", next_bin));
          total += int'(hist);
        end
        next_bin++;
      end
      if (read_finish) finishes++;
      r = next_rand();
      read_en = toggle ? r[4] : 1'b1;
    end
    read_en = 1'b0;
    repeat (4) begin // Watch for stray outputs after the pulse.
      @(negedge clk);
      if (read_finish) finishes++;
      if (hist_valid) next_bin++;
    end
    if (next_bin != NUM_BINS) begin
      err_cnt++;
      $display("Read-out delivered %0d bins instead of %0d.", next_bin, NUM_BINS);
    end
    if (finishes != 1) begin
      err_cnt++;
      $display("Read finish pulsed %0d times instead of once.", finishes);
    end
    if (busy) begin
      err_cnt++;
      $display("Engine still busy after the read-out finished.");
    end
  endtask

  task automatic begin_test();
    test_err_base = err_cnt;
  endtask

  task automatic end_test(input string name);
    test_cnt++;
    if (err_cnt == test_err_base) begin
      $display("Test %0d %s: ok", test_cnt, name);
    end else begin
      bad_test_cnt++;
      $display("Test %0d %s: %0d errors", test_cnt, name, err_cnt - test_err_base);
    end
  endtask

  task automatic run_frame(input bit stalls, input bit toggle, output int total);
    start_frame();
    send_frame(stalls);
    read_hist(toggle, total);
  endtask

  task automatic set_flat(input pix_t value);
    for (int i = 0; i < NPIX; i++) begin
      frame[i] = value;
    end
    for (int b = 0; b < NUM_BINS; b++) begin
      exp_cnt[b] = 0;
    end
    exp_cnt[NUM_BINS-1] = NWIN; // Every comparison ties.
  endtask

  task automatic flat_frame();
    int total;
    begin_test();
    set_flat(8'h5a);
    run_frame(1'b0, 1'b0, total);
    end_test("flat frame");
  endtask

  task automatic ramp_frame();
    int total;
    begin_test();
    for (int i = 0; i < NPIX; i++) begin
      frame[i] = pix_t'(16 * (i % IMG_COLS) + 2 * (i / IMG_COLS));
    end
    build_expected();
    run_frame(1'b0, 1'b0, total);
    end_test("ramp frame");
  endtask

  task automatic random_frame();
    int total;
    begin_test();
    fill_random(1'b0);
    build_expected();
    run_frame(1'b1, 1'b0, total);
    check_count(count_t'(total), count_t'(NWIN), "Sum of bins");
    end_test("random frame");
  endtask

  task automatic read_backpressure();
    int total;
    begin_test();
    fill_random(1'b1);
    build_expected();
    run_frame(1'b0, 1'b1, total);
    end_test("read back-pressure");
  endtask

  task automatic second_frame();
    logic [31:0] r;
    int total;
    begin_test();
    set_flat(8'h20);
    run_frame(1'b0, 1'b0, total);
    // Enough rows to reach interior windows right before the start.
    for (int k = 0; k < 3 * IMG_COLS; k++) begin
      r = next_rand();
      pix_valid = 1'b1;
      pix = r[7:0];
      @(negedge clk);
      if (busy) begin
        err_cnt++;
        $display("Engine left idle on pixel input without a start.");
      end
    end
    pix_valid = 1'b0;
    fill_random(1'b0);
    build_expected();
    run_frame(1'b1, 1'b0, total);
    end_test("second frame");
  endtask

  initial begin
    rst_n = 1'b0;
    start = 1'b0;
    pix_valid = 1'b0;
    read_en = 1'b0;
    pix = '0;
    apply_reset();
    flat_frame();
    ramp_frame();
    random_frame();
    read_backpressure();
    second_frame();
    $display("Summary: %0d tests run, %0d with errors, %0d errors in total",
             test_cnt, bad_test_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== texture_hist_top.f ====
texture_hist_pkg.sv
raster_counter.sv
line_window.sv
median_code.sv
joint_hist.sv
hist_ctrl.sv
texture_hist_top.sv
texture_hist_chk.sv
texture_hist_tb.sv

// ==== texture_hist_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module texture_hist_top
  import texture_hist_pkg::*;
(
  input  logic   clk,
  input  logic   rst_n,
  input  logic   start_i,
  input  logic   pix_valid_i,
  input  logic   read_en_i,
  input  pix_t   pix_i,
  output count_t hist_o,
  output bin_t   hist_bin_o,
  output logic   hist_valid_o,
  output logic   read_finish_o,
  output logic   busy_o
);

  logic   accum_en;
  logic   clear;
  logic   step;
  logic   center_ok;
  logic   frame_last;
  pix_t   win [9];
  logic   win_valid;
  logic   win_last;
  bin_t   code_bin;
  logic   code_valid;
  logic   code_last;
  bin_t   rd_bin;
  count_t rd_count;

  assign step = pix_valid_i && accum_en; // Pixels outside accumulate are dropped.

  raster_counter u_raster_counter (
    .clk          (clk),
    .rst_n        (rst_n),
    .clear_i      (clear),
    .step_i       (step),
    .center_ok_o  (center_ok),
    .frame_last_o (frame_last)
  );

  line_window u_line_window (
    .clk         (clk),
    .rst_n       (rst_n),
    .pix_i       (pix_i),
    .step_i      (step),
    .center_ok_i (center_ok),
    .last_i      (frame_last),
    .win_o       (win),
    .win_valid_o (win_valid),
    .win_last_o  (win_last)
  );

  median_code u_median_code (
    .clk          (clk),
    .rst_n        (rst_n),
    .win_i        (win),
    .win_valid_i  (win_valid),
    .win_last_i   (win_last),
    .code_bin_o   (code_bin),
    .code_valid_o (code_valid),
    .code_last_o  (code_last)
  );

  joint_hist u_joint_hist (
    .clk        (clk),
    .rst_n      (rst_n),
    .clear_i    (clear),
    .inc_i      (code_valid),
    .inc_bin_i  (code_bin),
    .rd_bin_i   (rd_bin),
    .rd_count_o (rd_count)
  );

  hist_ctrl u_hist_ctrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .start_i       (start_i),
    .read_en_i     (read_en_i),
    .code_last_i   (code_last),
    .rd_count_i    (rd_count),
    .accum_en_o    (accum_en),
    .clear_o       (clear),
    .rd_bin_o      (rd_bin),
    .hist_bin_o    (hist_bin_o),
    .hist_o        (hist_o),
    .hist_valid_o  (hist_valid_o),
    .read_finish_o (read_finish_o),
    .busy_o        (busy_o)
  );

endmodule

`default_nettype wire
